/* matmul_config.svh */
`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

// Rows, columns and lanes of the systolic tile
`define TILE_SIZE 4

// Number of k steps per product, also the A and B memory depth
`define INNER_DEPTH 4

// Element width, two's complement
`define DWIDTH 16

// Address width of all three operand memories
`define AWIDTH 2

// Cycle count at which the run is reported complete
`define TILE_DONE_CYCLES 20

// Sequencer counter width
`define CNT_WIDTH 6

`endif

/* matmul_pkg.sv */
`include "matmul_config.svh"

package matmul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  // One matrix element
  typedef logic signed [`DWIDTH-1:0] elem_t;

  // One memory word, lane 0 in the low bits
  typedef elem_t [`TILE_SIZE-1:0] row_t;

  // Word address in the A, B and C memories
  typedef logic [`AWIDTH-1:0] addr_t;

  // Sequencer cycle count
  typedef logic [`CNT_WIDTH-1:0] cnt_t;

endpackage

/* sram_1p.sv */
`timescale 1ns/10ps

module sram_1p #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 64
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [WIDTH-1:0]         d,
  output logic [WIDTH-1:0]         q
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Read returns the old word when the same address is written
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= d;
    end
    q <= mem[addr];
  end

endmodule

/* operand_skew.sv */
`timescale 1ns/10ps
`include "matmul_config.svh"

module operand_skew
  import matmul_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic valid,
  input  row_t row_in,
  output row_t row_out
);

  row_t masked;

  // Idle cycles push zeros so the grid accumulates nothing
  assign masked = valid ? row_in : '0;

  for (genvar n = 0; n < `TILE_SIZE; n++) begin : g_lane
    if (n == 0) begin : g_direct
      assign row_out[0] = masked[0];
    end else begin : g_delay
      elem_t stage [n];

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          for (int s = 0; s < n; s++) begin
            stage[s] <= '0;
          end
        end else begin
          stage[0] <= masked[n];
          for (int s = 1; s < n; s++) begin
            stage[s] <= stage[s-1];
          end
        end
      end

      // Lane n leaves after n registers
      assign row_out[n] = stage[n-1];
    end
  end

endmodule

/* processing_element.sv */
`timescale 1ns/10ps
`include "matmul_config.svh"

module processing_element
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  elem_t in_a,
  input  elem_t in_b,
  output elem_t out_a,
  output elem_t out_b,
  output elem_t out_c
);

  logic signed [2*`DWIDTH-1:0] prod;
  elem_t                       acc;

  assign prod = in_a * in_b;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      out_a <= '0;
      out_b <= '0;
      acc   <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
      // Only the low half of the product matters, the sum wraps
      acc   <= acc + prod[`DWIDTH-1:0];
    end
  end

  assign out_c = acc;

endmodule

/* tile_sequencer.sv */
`timescale 1ns/10ps
`include "matmul_config.svh"

module tile_sequencer
  import matmul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start_mat_mul,
  output addr_t                 a_addr,
  output addr_t                 b_addr,
  output logic                  operand_valid,
  output logic [`TILE_SIZE-1:0] row_latch_en,
  output logic                  clear,
  output logic                  done_mat_mul
);

  // Row 0 holds its last product one cycle before this count
  localparam int LATCH_BASE = `INNER_DEPTH + `TILE_SIZE;

  cnt_t cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Cycle counter and done flag
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      cnt          <= '0;
      done_mat_mul <= 1'b0;
    end else if (cnt == cnt_t'(`TILE_DONE_CYCLES)) begin
      done_mat_mul <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign clear = !start_mat_mul;

  ////////////////////////////////////////////////////////////////////////////
  // Operand reads
  ////////////////////////////////////////////////////////////////////////////

  // Word k is read at count k and shows on the RAM output one cycle later
  assign a_addr = addr_t'(cnt);
  assign b_addr = addr_t'(cnt);

  assign operand_valid = (cnt != '0) && (cnt <= cnt_t'(`INNER_DEPTH));

  // Staggered by one cycle per row, as the wavefront reaches the last column
  for (genvar i = 0; i < `TILE_SIZE; i++) begin : g_latch
    assign row_latch_en[i] = (cnt == cnt_t'(LATCH_BASE + i));
  end

endmodule

/* systolic_tile.sv */
`timescale 1ns/10ps
`include "matmul_config.svh"

module systolic_tile
  import matmul_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  row_t                  a_row,
  input  row_t                  b_row,
  input  logic [`TILE_SIZE-1:0] row_latch_en,
  output logic                  c_row_we,
  output addr_t                 c_row_addr,
  output row_t                  c_row_data
);

  // A moves right along a row, B moves down along a column
  elem_t a_h [`TILE_SIZE][`TILE_SIZE+1];
  elem_t b_v [`TILE_SIZE+1][`TILE_SIZE];
  row_t  acc_row [`TILE_SIZE];
  row_t  row_q [`TILE_SIZE];

  ////////////////////////////////////////////////////////////////////////////
  // PE grid
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `TILE_SIZE; i++) begin : g_row
    assign a_h[i][0] = a_row[i];
    assign b_v[0][i] = b_row[i];

    for (genvar j = 0; j < `TILE_SIZE; j++) begin : g_col
      processing_element i_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_h[i][j]),
        .in_b  (b_v[i][j]),
        .out_a (a_h[i][j+1]),
        .out_b (b_v[i+1][j]),
        .out_c (acc_row[i][j])
      );
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result rows
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < `TILE_SIZE; i++) begin
      if (row_latch_en[i]) begin
        row_q[i] <= acc_row[i];
      end
    end
  end

  // One C write per latched row, in the following cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      c_row_we   <= 1'b0;
      c_row_addr <= '0;
    end else begin
      c_row_we <= |row_latch_en;
      for (int i = 0; i < `TILE_SIZE; i++) begin
        if (row_latch_en[i]) begin
          c_row_addr <= addr_t'(i);
        end
      end
    end
  end

  assign c_row_data = row_q[c_row_addr];

endmodule

/* matrix_multiplication.sv */
`timescale 1ns/10ps
`include "matmul_config.svh"

module matrix_multiplication
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  we_a,
  input  logic  we_b,
  input  logic  read_c,
  input  logic  start_mat_mul,
  input  addr_t addr_pi,
  input  row_t  data_pi,
  output logic  done_mat_mul,
  output row_t  data_from_out_mat
);

  addr_t addr_reg;
  addr_t a_addr_seq;
  addr_t b_addr_seq;
  addr_t mem_a_addr;
  addr_t mem_b_addr;
  addr_t mem_c_addr;
  addr_t c_row_addr;
  row_t  a_q;
  row_t  b_q;
  row_t  a_skewed;
  row_t  b_skewed;
  row_t  c_row_data;
  row_t  c_q;
  logic  operand_valid;
  logic  clear;
  logic  c_row_we;
  logic  read_d1;
  logic  read_d2;
  logic [`TILE_SIZE-1:0] row_latch_en;

  ////////////////////////////////////////////////////////////////////////////
  // Host address and read strobe pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_reg <= '0;
      read_d1  <= 1'b0;
      read_d2  <= 1'b0;
    end else begin
      addr_reg <= addr_pi;
      read_d1  <= read_c;
      read_d2  <= read_d1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand memories
  ////////////////////////////////////////////////////////////////////////////

  // Host writes land on the strobe edge, the sequencer owns reads otherwise
  assign mem_a_addr = we_a ? addr_pi : a_addr_seq;
  assign mem_b_addr = we_b ? addr_pi : b_addr_seq;

  sram_1p #(.DEPTH(`INNER_DEPTH), .WIDTH($bits(row_t))) mem_a (
    .clk  (clk),
    .we   (we_a),
    .addr (mem_a_addr),
    .d    (data_pi),
    .q    (a_q)
  );

  sram_1p #(.DEPTH(`INNER_DEPTH), .WIDTH($bits(row_t))) mem_b (
    .clk  (clk),
    .we   (we_b),
    .addr (mem_b_addr),
    .d    (data_pi),
    .q    (b_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer, skew and PE grid
  ////////////////////////////////////////////////////////////////////////////

  tile_sequencer i_tile_sequencer (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_addr        (a_addr_seq),
    .b_addr        (b_addr_seq),
    .operand_valid (operand_valid),
    .row_latch_en  (row_latch_en),
    .clear         (clear),
    .done_mat_mul  (done_mat_mul)
  );

  operand_skew i_skew_a (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .valid   (operand_valid),
    .row_in  (a_q),
    .row_out (a_skewed)
  );

  operand_skew i_skew_b (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .valid   (operand_valid),
    .row_in  (b_q),
    .row_out (b_skewed)
  );

  systolic_tile i_systolic_tile (
    .clk          (clk),
    .reset        (reset),
    .clear        (clear),
    .a_row        (a_skewed),
    .b_row        (b_skewed),
    .row_latch_en (row_latch_en),
    .c_row_we     (c_row_we),
    .c_row_addr   (c_row_addr),
    .c_row_data   (c_row_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result memory and read-back
  ////////////////////////////////////////////////////////////////////////////

  assign mem_c_addr = c_row_we ? c_row_addr : addr_reg;

  sram_1p #(.DEPTH(`TILE_SIZE), .WIDTH($bits(row_t))) mem_c (
    .clk  (clk),
    .we   (c_row_we),
    .addr (mem_c_addr),
    .d    (c_row_data),
    .q    (c_q)
  );

  // Holds the last row read until the next read strobe comes through
  always_ff @(posedge clk) begin
    if (reset) begin
      data_from_out_mat <= '0;
    end else if (read_d2) begin
      data_from_out_mat <= c_q;
    end
  end

endmodule

/* matmul_sva.sv */
`timescale 1ns/10ps

module matmul_sva (
  input logic clk,
  input logic reset,
  input logic we_a,
  input logic we_b,
  input logic read_c,
  input logic start_mat_mul,
  input logic done_mat_mul
);

  int assert_fails = 0;

  // Only one operand memory takes the host word
  a_single_write: assert property (@(posedge clk) disable iff (reset) !(we_a && we_b))
    else begin
      $error("we_a and we_b are high in the same cycle");
      assert_fails++;
    end

  // Done drops on the first edge that sees start low
  a_done_falls: assert property (@(posedge clk) disable iff (reset)
    !start_mat_mul |=> !done_mat_mul)
    else begin
      $error("done_mat_mul still high one cycle after start_mat_mul went low");
      assert_fails++;
    end

  // Host owns the memories only between runs
  a_quiet_run: assert property (@(posedge clk) disable iff (reset)
    start_mat_mul |-> !(we_a || we_b || read_c))
    else begin
      $error("host strobe active while start_mat_mul is high");
      assert_fails++;
    end

endmodule

/* matmul_checker.sv */
`timescale 1ns/10ps
`include "matmul_config.svh"

module matmul_checker
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  we_a,
  input  logic  we_b,
  input  logic  read_c,
  input  logic  start_mat_mul,
  input  addr_t addr_pi,
  input  row_t  data_pi,
  input  logic  done_mat_mul,
  input  row_t  data_from_out_mat,
  input  int    test_id,
  output int    data_errors,
  output int    done_errors
);

  // Mirrors of the operand memories, same word layout as the DUT
  row_t a_words [`INNER_DEPTH];
  row_t b_words [`INNER_DEPTH];

  // Two stages of read latency, then the held output
  logic rd_s1;
  logic rd_s2;
  row_t row_s1;
  row_t row_s2;
  row_t exp_out;
  logic exp_done;
  int   run_edges;

  function automatic string test_label(input int id);
    case (id)
      0: return "reset";
      1: return "identity";
      2: return "random";
      3: return "second_run";
      4: return "extremes";
      default: return "unknown";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference product, low 16 bits of each sum
  ////////////////////////////////////////////////////////////////////////////

  function automatic row_t ref_row(input addr_t i);
    row_t        r;
    logic [15:0] acc;
    int          prod;
    for (int j = 0; j < `TILE_SIZE; j++) begin
      acc = '0;
      for (int k = 0; k < `INNER_DEPTH; k++) begin
        prod = $signed(a_words[k][i]) * $signed(b_words[k][j]);
        acc  = acc + prod[15:0];
      end
      r[j] = acc;
    end
    return r;
  endfunction

  initial begin
    data_errors = 0;
    done_errors = 0;
  end

  always @(posedge clk) begin
    if (reset) begin
      rd_s1     = 1'b0;
      rd_s2     = 1'b0;
      exp_out   = '0;
      exp_done  = 1'b0;
      run_edges = 0;
    end else begin
      if (data_from_out_mat !== exp_out) begin
        $display("FAILED %s data_from_out_mat: expected %h, actual %h",
                 test_label(test_id), exp_out, data_from_out_mat);
        data_errors++;
      end
      if (done_mat_mul !== exp_done) begin
        $display("FAILED %s done_mat_mul: expected %0b, actual %0b",
                 test_label(test_id), exp_done, done_mat_mul);
        done_errors++;
      end

      // Advance the read model
      if (rd_s2) begin
        exp_out = row_s2;
      end
      rd_s2  = rd_s1;
      row_s2 = row_s1;
      rd_s1  = read_c;
      if (read_c) begin
        row_s1 = ref_row(addr_pi);
      end

      // Done is due on the edge that sees start for the 21st time
      if (start_mat_mul) begin
        exp_done = (run_edges >= `TILE_DONE_CYCLES);
        run_edges++;
      end else begin
        exp_done  = 1'b0;
        run_edges = 0;
      end

      if (we_a) begin
        a_words[addr_pi] = data_pi;
      end
      if (we_b) begin
        b_words[addr_pi] = data_pi;
      end
    end
  end

endmodule

/* tb_matrix_multiplication.sv */
`timescale 1ns/10ps
`include "matmul_config.svh"

module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

module tb_matrix_multiplication
  import matmul_pkg::*;
();

  // About 60 cycles per run, five runs, wide margin
  localparam int RUN_CYCLES     = 60;
  localparam int NUM_RUNS       = 5;
  localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES * 5;

  logic  clk;
  logic  reset;
  logic  we_a;
  logic  we_b;
  logic  read_c;
  logic  start_mat_mul;
  addr_t addr_pi;
  row_t  data_pi;
  logic  done_mat_mul;
  row_t  data_from_out_mat;
  int    seed;
  int    test_id;
  int    data_errors;
  int    done_errors;
  int    cycle_cnt;
  int    total;

  tb_clock_gen #(.PERIOD(100)) i_clock_gen (.clk(clk));

  matrix_multiplication i_matrix_multiplication (
    .clk               (clk),
    .reset             (reset),
    .we_a              (we_a),
    .we_b              (we_b),
    .read_c            (read_c),
    .start_mat_mul     (start_mat_mul),
    .addr_pi           (addr_pi),
    .data_pi           (data_pi),
    .done_mat_mul      (done_mat_mul),
    .data_from_out_mat (data_from_out_mat)
  );

  matmul_checker i_matmul_checker (
    .clk               (clk),
    .reset             (reset),
    .we_a              (we_a),
    .we_b              (we_b),
    .read_c            (read_c),
    .start_mat_mul     (start_mat_mul),
    .addr_pi           (addr_pi),
    .data_pi           (data_pi),
    .done_mat_mul      (done_mat_mul),
    .data_from_out_mat (data_from_out_mat),
    .test_id           (test_id),
    .data_errors       (data_errors),
    .done_errors       (done_errors)
  );

  bind matrix_multiplication matmul_sva i_matmul_sva (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic row_t random_row();
    row_t r;
    for (int n = 0; n < `TILE_SIZE; n++) begin
      r[n] = elem_t'($random(seed));
    end
    return r;
  endfunction

  // Values at and next to both ends of the signed range
  function automatic row_t extreme_row();
    row_t r;
    for (int n = 0; n < `TILE_SIZE; n++) begin
      case ($unsigned($random(seed)) % 5)
        0: r[n] = 16'h7FFF;
        1: r[n] = 16'h8000;
        2: r[n] = 16'h7FFE;
        3: r[n] = 16'h8001;
        default: r[n] = 16'hFFFF;
      endcase
    end
    return r;
  endfunction

  function automatic row_t identity_row(input int k);
    row_t r;
    for (int j = 0; j < `TILE_SIZE; j++) begin
      r[j] = (j == k) ? elem_t'(1) : elem_t'(0);
    end
    return r;
  endfunction

  task automatic write_word(input logic to_b, input int addr, input row_t word);
    @(posedge clk);
    we_a    <= !to_b;
    we_b    <= to_b;
    addr_pi <= addr_t'(addr);
    data_pi <= word;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      we_a   <= 1'b0;
      we_b   <= 1'b0;
      read_c <= 1'b0;
    end
  endtask

  // Hold start through done and a few cycles more, the cycle counter catches a hang
  task automatic run_tile();
    idle(1);
    @(posedge clk);
    start_mat_mul <= 1'b1;
    do @(posedge clk); while (!done_mat_mul);
    repeat (3) @(posedge clk);
    start_mat_mul <= 1'b0;
    idle(2);
  endtask

  task automatic read_rows();
    for (int i = 0; i < `TILE_SIZE; i++) begin
      @(posedge clk);
      read_c  <= 1'b1;
      addr_pi <= addr_t'(i);
    end
    idle(5);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 95995;
    test_id       = 0;
    reset         = 1'b1;
    we_a          = 1'b0;
    we_b          = 1'b0;
    read_c        = 1'b0;
    start_mat_mul = 1'b0;
    addr_pi       = '0;
    data_pi       = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    idle(3);

    test_id <= 1;
    for (int k = 0; k < `INNER_DEPTH; k++) begin
      write_word(1'b0, k, random_row());
    end
    for (int k = 0; k < `INNER_DEPTH; k++) begin
      write_word(1'b1, k, identity_row(k));
    end
    run_tile();
    read_rows();

    test_id <= 2;
    for (int k = 0; k < `INNER_DEPTH; k++) begin
      write_word(1'b0, k, random_row());
      write_word(1'b1, k, random_row());
    end
    run_tile();
    read_rows();

    // Same A, new B, no reset in between
    test_id <= 3;
    for (int k = 0; k < `INNER_DEPTH; k++) begin
      write_word(1'b1, k, random_row());
    end
    run_tile();
    read_rows();

    test_id <= 4;
    for (int k = 0; k < `INNER_DEPTH; k++) begin
      write_word(1'b0, k, extreme_row());
      write_word(1'b1, k, extreme_row());
    end
    run_tile();
    read_rows();

    idle(2);
    @(negedge clk);
    total = data_errors + done_errors + i_matrix_multiplication.i_matmul_sva.assert_fails;
    $display("Errors: data %0d, done timing %0d, assertions %0d, total %0d",
             data_errors, done_errors, i_matrix_multiplication.i_matmul_sva.assert_fails,
             total);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Simulation hung, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* matrix_multiplication.f */
+incdir+.
matmul_pkg.sv
sram_1p.sv
operand_skew.sv
processing_element.sv
tile_sequencer.sv
systolic_tile.sv
matrix_multiplication.sv
matmul_sva.sv
matmul_checker.sv
tb_matrix_multiplication.sv

/* Bender.yml */
package:
  name: matrix_multiplication

sources:
  - include_dirs:
      - .
    files:
      - matmul_pkg.sv
      - sram_1p.sv
      - operand_skew.sv
      - processing_element.sv
      - tile_sequencer.sv
      - systolic_tile.sv
      - matrix_multiplication.sv
  - target: test
    include_dirs:
      - .
    files:
      - matmul_sva.sv
      - matmul_checker.sv
      - tb_matrix_multiplication.sv
